/* common/dcache_bus_pkg.sv */
package dcache_bus_pkg;

	////////////////////
	// CPU side
	////////////////////

	// Command from generator to cache
	typedef struct packed {
		logic                                 wr;   // 1 write, 0 read
		logic [dcache_cfg_pkg::ADDR_W-1:0]    addr; // Word address
		logic [dcache_cfg_pkg::DATA_W-1:0]    data; // Write data
	} cpu_req_t;

	// Response from cache
	typedef struct packed {
		logic [dcache_cfg_pkg::DATA_W-1:0]    data; // Read data, don't-care on writes
	} cpu_rsp_t;

	////////////////////
	// Memory side
	////////////////////

	// Command from cache to memory
	typedef struct packed {
		logic                                 wr;   // 1 write, 0 read
		logic [dcache_cfg_pkg::ADDR_W-1:0]    addr; // Word address, aliased in memory
		logic [dcache_cfg_pkg::DATA_W-1:0]    data; // Write data
	} mem_req_t;

	// Response from memory
	typedef struct packed {
		logic [dcache_cfg_pkg::DATA_W-1:0]    data; // Read data
	} mem_rsp_t;

endpackage

/* common/dcache_cfg_pkg.sv */
package dcache_cfg_pkg;

	////////////////////
	// Widths
	////////////////////

	localparam int ADDR_W = 28; // Word address, DDR2 side
	localparam int DATA_W = 32; // One word per line

	////////////////////
	// Generator LFSR
	////////////////////

	// 32-bit Galois LFSR, right shift
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	// One LFSR step
	function automatic logic [31:0] lfsr_step(input logic [31:0] cur);
		logic [31:0] nxt;
		nxt = cur >> 1; // Shift right by one
		if (cur[0])
		begin
			nxt = nxt ^ LFSR_TAPS; // Feedback on shifted-out one
		end
		return nxt;
	endfunction

endpackage

/* dcache/dcache.sv */
module dcache #(
	parameter int INDEX_BITS = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start,
	input  dcache_bus_pkg::cpu_req_t cpu_req,
	input  logic                     cpu_req_valid,
	output logic                     cpu_req_ready,
	output dcache_bus_pkg::cpu_rsp_t cpu_rsp,
	output logic                     cpu_rsp_valid,
	output dcache_bus_pkg::mem_req_t mem_req,
	output logic                     mem_req_valid,
	input  logic                     mem_req_ready,
	input  dcache_bus_pkg::mem_rsp_t mem_rsp,
	input  logic                     mem_rsp_valid,
	output logic [6:0]               hit_count,
	output logic [6:0]               miss_count
);
	import dcache_cfg_pkg::*;
	import dcache_bus_pkg::*;

	localparam int LINES = 1 << INDEX_BITS;
	localparam int TAG_W = ADDR_W - INDEX_BITS;

	typedef enum logic [1:0] {
		S_LOOKUP,  // Ready for a CPU command
		S_MEM_REQ, // Presenting to memory
		S_MEM_WAIT // Waiting for memory response
	} state_t;

	state_t                 state;
	logic [LINES-1:0]       line_valid;
	logic [TAG_W-1:0]       tag_mem [LINES];
	logic [DATA_W-1:0]      data_mem [LINES];
	cpu_req_t               req_q;     // Command in flight
	logic [INDEX_BITS-1:0]  in_index;
	logic [TAG_W-1:0]       in_tag;
	logic [INDEX_BITS-1:0]  q_index;
	logic [TAG_W-1:0]       q_tag;
	logic [DATA_W-1:0]      fill_data;
	logic                   accept;
	logic                   lookup_hit;
	logic                   read_hit;
	logic                   fill;

	////////////////////
	// Lookup
	////////////////////

	assign in_index   = cpu_req.addr[INDEX_BITS-1:0];
	assign in_tag     = cpu_req.addr[ADDR_W-1:INDEX_BITS];
	assign q_index    = req_q.addr[INDEX_BITS-1:0];
	assign q_tag      = req_q.addr[ADDR_W-1:INDEX_BITS];

	assign cpu_req_ready = (state == S_LOOKUP);
	assign accept        = cpu_req_valid && cpu_req_ready;
	assign lookup_hit    = line_valid[in_index] && (tag_mem[in_index] == in_tag);
	assign read_hit      = accept && !cpu_req.wr && lookup_hit; // Served from the line
	assign fill          = (state == S_MEM_WAIT) && mem_rsp_valid;
	assign fill_data     = req_q.wr ? req_q.data : mem_rsp.data; // Write data or read fill

	// Writes and misses go through unchanged
	assign mem_req_valid = (state == S_MEM_REQ);
	assign mem_req       = '{wr: req_q.wr, addr: req_q.addr, data: req_q.data};

	////////////////////
	// Control FSM
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state         <= S_LOOKUP;
			cpu_rsp_valid <= 1'b0;
			line_valid    <= '0; // Cache starts empty
		end
		else
		begin
			cpu_rsp_valid <= 1'b0;
			case (state)
				S_LOOKUP:
				begin
					if (read_hit)
					begin
						cpu_rsp_valid <= 1'b1; // Hit answers next cycle
					end
					else if (accept)
					begin
						state <= S_MEM_REQ; // Write or read miss
					end
				end
				S_MEM_REQ:
				begin
					if (mem_req_ready)
					begin
						state <= S_MEM_WAIT;
					end
				end
				S_MEM_WAIT:
				begin
					if (mem_rsp_valid)
					begin
						state                <= S_LOOKUP;
						cpu_rsp_valid        <= 1'b1;
						line_valid[q_index]  <= 1'b1; // Write-allocate or read fill
					end
				end
				default:
				begin
					state <= S_LOOKUP;
				end
			endcase
		end
	end

	// Line store and response data
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req_q <= cpu_req;
		end
		if (read_hit)
		begin
			cpu_rsp.data <= data_mem[in_index];
		end
		else if (fill)
		begin
			tag_mem[q_index]  <= q_tag;
			data_mem[q_index] <= fill_data;
			cpu_rsp.data      <= fill_data;
		end
	end

	////////////////////
	// Read counters
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst || start)
		begin
			hit_count  <= 7'd0;
			miss_count <= 7'd0;
		end
		else if (accept && !cpu_req.wr)
		begin
			if (lookup_hit)
			begin
				hit_count <= hit_count + 7'd1;
			end
			else
			begin
				miss_count <= miss_count + 7'd1;
			end
		end
	end

endmodule

/* list.f */
common/dcache_cfg_pkg.sv
common/dcache_bus_pkg.sv
traffic_gen/dcache_traffic_gen.sv
dcache/dcache.sv
rtl/dram_model.sv
rtl/dcache_top.sv
verif/dcache_properties.sv
verif/dcache_monitor.sv
verif/dcache_tb.sv

/* rtl/dcache_top.sv */
module dcache_top #(
	parameter int CYCLE_DELAY   = 3,
	parameter int INDEX_BITS    = 4,
	parameter int MEM_ADDR_BITS = 8,  // Not below INDEX_BITS
	parameter int MEM_LATENCY   = 4   // At least 1
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	input  logic [31:0] seed,
	input  logic [6:0]  burst_len,
	output logic        busy,
	output logic        done,
	output logic        error,
	output logic [6:0]  err_count,
	output logic [6:0]  hit_count,
	output logic [6:0]  miss_count
);
	import dcache_bus_pkg::*;

	////////////////////
	// Stage links
	////////////////////

	cpu_req_t cpu_req;       // Generator to cache
	logic     cpu_req_valid;
	logic     cpu_req_ready;
	cpu_rsp_t cpu_rsp;       // Cache to generator
	logic     cpu_rsp_valid;
	mem_req_t mem_req;       // Cache to memory
	logic     mem_req_valid;
	logic     mem_req_ready;
	mem_rsp_t mem_rsp;       // Memory to cache
	logic     mem_rsp_valid;

	dcache_traffic_gen #(
		.CYCLE_DELAY (CYCLE_DELAY)
	) gen_i (
		.clk           (clk),
		.rst           (rst),
		.start         (start),
		.seed          (seed),
		.burst_len     (burst_len),
		.cpu_req       (cpu_req),
		.cpu_req_valid (cpu_req_valid),
		.cpu_req_ready (cpu_req_ready),
		.cpu_rsp       (cpu_rsp),
		.cpu_rsp_valid (cpu_rsp_valid),
		.busy          (busy),
		.done          (done),
		.error         (error),
		.err_count     (err_count)
	);

	dcache #(
		.INDEX_BITS (INDEX_BITS)
	) cache_i (
		.clk           (clk),
		.rst           (rst),
		.start         (start && !busy), // Counters keep running through a burst
		.cpu_req       (cpu_req),
		.cpu_req_valid (cpu_req_valid),
		.cpu_req_ready (cpu_req_ready),
		.cpu_rsp       (cpu_rsp),
		.cpu_rsp_valid (cpu_rsp_valid),
		.mem_req       (mem_req),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_rsp       (mem_rsp),
		.mem_rsp_valid (mem_rsp_valid),
		.hit_count     (hit_count),
		.miss_count    (miss_count)
	);

	dram_model #(
		.MEM_ADDR_BITS (MEM_ADDR_BITS),
		.MEM_LATENCY   (MEM_LATENCY)
	) mem_i (
		.clk           (clk),
		.rst           (rst),
		.mem_req       (mem_req),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_rsp       (mem_rsp),
		.mem_rsp_valid (mem_rsp_valid)
	);

endmodule

/* rtl/dram_model.sv */
module dram_model #(
	parameter int MEM_ADDR_BITS = 8,
	parameter int MEM_LATENCY   = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  dcache_bus_pkg::mem_req_t mem_req,
	input  logic                     mem_req_valid,
	output logic                     mem_req_ready,
	output dcache_bus_pkg::mem_rsp_t mem_rsp,
	output logic                     mem_rsp_valid
);
	import dcache_cfg_pkg::*;

	localparam int WORDS = 1 << MEM_ADDR_BITS;
	localparam int LAT_W = $clog2(MEM_LATENCY + 1);

	logic [DATA_W-1:0]        mem_array [WORDS];
	logic [MEM_ADDR_BITS-1:0] word_addr; // Upper address bits alias
	logic [LAT_W-1:0]         lat_cnt;
	logic                     busy;
	logic                     accept;

	assign mem_req_ready = !busy;
	assign accept        = mem_req_valid && mem_req_ready;
	assign word_addr     = mem_req.addr[MEM_ADDR_BITS-1:0];

	// Latency counter
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy          <= 1'b0;
			mem_rsp_valid <= 1'b0;
			lat_cnt       <= '0;
		end
		else
		begin
			mem_rsp_valid <= 1'b0;
			if (accept)
			begin
				if (MEM_LATENCY <= 1)
				begin
					mem_rsp_valid <= 1'b1; // Respond next cycle
				end
				else
				begin
					busy    <= 1'b1;
					lat_cnt <= LAT_W'(MEM_LATENCY - 1);
				end
			end
			else if (busy)
			begin
				if (lat_cnt == LAT_W'(1))
				begin
					busy          <= 1'b0;
					mem_rsp_valid <= 1'b1;
				end
				else
				begin
					lat_cnt <= lat_cnt - LAT_W'(1);
				end
			end
		end
	end

	// Word array, read captured at acceptance
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			if (mem_req.wr)
			begin
				mem_array[word_addr] <= mem_req.data;
			end
			mem_rsp.data <= mem_array[word_addr];
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f list.f \
	-o dcache_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/dcache_sim +verilator+error+limit+100 > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q -F '*** FAILED ***' sim.log && exit 1 || exit 0

/* traffic_gen/dcache_traffic_gen.sv */
module dcache_traffic_gen #(
	parameter int CYCLE_DELAY = 3
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start,
	input  logic [31:0]              seed,
	input  logic [6:0]               burst_len,
	output dcache_bus_pkg::cpu_req_t cpu_req,
	output logic                     cpu_req_valid,
	input  logic                     cpu_req_ready,
	input  dcache_bus_pkg::cpu_rsp_t cpu_rsp,
	input  logic                     cpu_rsp_valid,
	output logic                     busy,
	output logic                     done,
	output logic                     error,
	output logic [6:0]               err_count
);
	import dcache_cfg_pkg::*;

	localparam int CNT_W = $clog2(CYCLE_DELAY + 2); // Holds CYCLE_DELAY-1

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_WRITE,
		PH_READ
	} phase_t;

	phase_t           phase;
	logic [31:0]      lfsr;       // State after last slot's data step
	logic [31:0]      seed_q;     // Seed for the read replay
	logic [31:0]      start_seed; // Seed with zero replaced
	logic [31:0]      base_st;    // LFSR state the next slot starts from
	logic [31:0]      addr_st;    // Step one, address
	logic [31:0]      data_st;    // Step two, data
	logic [6:0]       slot_cnt;
	logic [6:0]       len_q;
	logic [CNT_W-1:0] idle_cnt;   // Pacing between commands
	logic             pacing;
	logic             last_slot;
	logic             mismatch;

	assign start_seed = (seed == 32'd0) ? 32'd1 : seed; // Zero would lock the LFSR
	assign last_slot  = (slot_cnt + 7'd1) >= len_q;

	////////////////////
	// Slot generation
	////////////////////

	always_comb
	begin
		if (phase == PH_IDLE)
		begin
			base_st = start_seed; // First write slot
		end
		else if (phase == PH_WRITE && last_slot)
		begin
			base_st = seed_q; // Replay from the seed for reads
		end
		else
		begin
			base_st = lfsr;
		end
	end

	assign addr_st  = lfsr_step(base_st);
	assign data_st  = lfsr_step(addr_st);
	assign mismatch = (phase == PH_READ) && (cpu_rsp.data != cpu_req.data); // Slot data held in req

	////////////////////
	// Phase machine
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			phase         <= PH_IDLE;
			cpu_req_valid <= 1'b0;
			busy          <= 1'b0;
			done          <= 1'b0;
			error         <= 1'b0;
			err_count     <= 7'd0;
			slot_cnt      <= 7'd0;
			pacing        <= 1'b0;
			idle_cnt      <= '0;
		end
		else
		begin
			done <= 1'b0; // Single-cycle pulse
			if (phase == PH_IDLE)
			begin
				if (start)
				begin
					seed_q        <= start_seed;
					len_q         <= burst_len;
					lfsr          <= data_st;
					cpu_req       <= '{wr: 1'b1, addr: addr_st[ADDR_W-1:0], data: data_st};
					cpu_req_valid <= 1'b1; // First command next cycle
					slot_cnt      <= 7'd0;
					busy          <= 1'b1;
					error         <= 1'b0;
					err_count     <= 7'd0;
					phase         <= PH_WRITE;
				end
			end
			else
			begin
				if (cpu_req_valid && cpu_req_ready)
				begin
					cpu_req_valid <= 1'b0; // Accepted, wait for response
				end
				if (cpu_rsp_valid)
				begin
					if (phase == PH_READ)
					begin
						error     <= mismatch; // Verdict of the last read
						err_count <= err_count + {6'd0, mismatch};
					end
					if (phase == PH_READ && last_slot)
					begin
						phase <= PH_IDLE; // Burst complete
						busy  <= 1'b0;
						done  <= 1'b1;
					end
					else
					begin
						if (last_slot)
						begin
							phase    <= PH_READ;
							slot_cnt <= 7'd0;
						end
						else
						begin
							slot_cnt <= slot_cnt + 7'd1;
						end
						lfsr    <= data_st;
						cpu_req <= '{wr: (phase == PH_WRITE) && !last_slot,
							addr: addr_st[ADDR_W-1:0], data: data_st};
						if (CYCLE_DELAY <= 1)
						begin
							cpu_req_valid <= 1'b1; // No gap
						end
						else
						begin
							pacing   <= 1'b1;
							idle_cnt <= CNT_W'(CYCLE_DELAY - 1);
						end
					end
				end
				else if (pacing)
				begin
					if (idle_cnt == CNT_W'(1))
					begin
						pacing        <= 1'b0;
						cpu_req_valid <= 1'b1; // Gap elapsed
					end
					else
					begin
						idle_cnt <= idle_cnt - CNT_W'(1);
					end
				end
			end
		end
	end

endmodule

/* verif/dcache_monitor.sv */
module dcache_monitor #(
	parameter int INDEX_BITS    = 4,
	parameter int MEM_ADDR_BITS = 8,
	parameter int RUN_TIMEOUT   = 5000
) (
	input logic        clk,
	input logic        rst,
	input logic        start,
	input logic [31:0] seed,
	input logic [6:0]  burst_len,
	input logic        busy,
	input logic        done,
	input logic        error,
	input logic [6:0]  err_count,
	input logic [6:0]  hit_count,
	input logic [6:0]  miss_count
);
	import dcache_cfg_pkg::*;

	localparam int LINES = 1 << INDEX_BITS;
	localparam int WORDS = 1 << MEM_ADDR_BITS;

	logic [ADDR_W-1:0] slot_addr [128];   // Slot sequence of the run
	logic [DATA_W-1:0] slot_data [128];
	logic [DATA_W-1:0] mem_word [WORDS];  // Aliased memory image
	logic              line_valid [LINES];
	logic [ADDR_W-1:0] line_addr [LINES]; // Full address, tag plus index
	int                exp_err;
	int                exp_hit;
	int                exp_miss;
	logic              exp_last_err;
	logic [31:0]       run_seed;
	logic [6:0]        run_len;
	logic [31:0]       prev_seed;         // Previous run, for the seed 0 vs 1 check
	logic [6:0]        prev_len;
	logic [6:0]        prev_err;
	logic [6:0]        prev_hit;
	logic [6:0]        prev_miss;
	logic              prev_valid;
	logic              pending;           // Run accepted, done not seen yet
	int                wait_cnt;
	int                run_count   = 0;
	int                check_count = 0;
	int                fail_count  = 0;

	// Right-shift Galois step
	function automatic logic [31:0] galois_next(input logic [31:0] cur);
		logic [31:0] nxt;
		nxt = {1'b0, cur[31:1]};
		if (cur[0] == 1'b1)
		begin
			nxt = nxt ^ LFSR_TAPS;
		end
		return nxt;
	endfunction

	////////////////////
	// Reference model
	////////////////////

	task automatic predict_run(input logic [31:0] new_seed, input logic [6:0] new_len);
		logic [31:0]       st;
		logic [DATA_W-1:0] rd;
		int                n;
		int                i;
		int                lidx;
		int                widx;
		n            = int'(new_len);
		st           = (new_seed == 32'd0) ? 32'd1 : new_seed; // Zero seed runs as one
		exp_err      = 0;
		exp_hit      = 0;
		exp_miss     = 0;
		exp_last_err = 1'b0;
		for (i = 0; i < n; i++)
		begin
			st           = galois_next(st);
			slot_addr[i] = st[ADDR_W-1:0];
			st           = galois_next(st);
			slot_data[i] = st;
		end
		for (i = 0; i < n; i++)
		begin
			widx            = int'(slot_addr[i][MEM_ADDR_BITS-1:0]);
			lidx            = int'(slot_addr[i][INDEX_BITS-1:0]);
			mem_word[widx]  = slot_data[i]; // Write-through
			line_valid[lidx] = 1'b1;        // Write-allocate
			line_addr[lidx] = slot_addr[i];
		end
		for (i = 0; i < n; i++)
		begin
			widx = int'(slot_addr[i][MEM_ADDR_BITS-1:0]);
			lidx = int'(slot_addr[i][INDEX_BITS-1:0]);
			if (line_valid[lidx] && line_addr[lidx] == slot_addr[i])
			begin
				exp_hit++;
			end
			else
			begin
				exp_miss++;
				line_valid[lidx] = 1'b1; // Read fill
				line_addr[lidx]  = slot_addr[i];
			end
			rd           = mem_word[widx]; // Last write to that word
			exp_last_err = (rd != slot_data[i]);
			if (exp_last_err)
			begin
				exp_err++;
			end
		end
	endtask

	////////////////////
	// Comparison
	////////////////////

	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] expected, inout int bad);
		check_count++;
		if (got !== expected)
		begin
			$display("MISMATCH %s: expected 0x%0h, got 0x%0h", name, expected, got);
			bad++;
		end
	endtask

	task automatic compare_run();
		int bad;
		bad = 0;
		check_field("err_count", {25'd0, err_count}, 32'(exp_err), bad);
		check_field("hit_count", {25'd0, hit_count}, 32'(exp_hit), bad);
		check_field("miss_count", {25'd0, miss_count}, 32'(exp_miss), bad);
		check_field("error", {31'd0, error}, {31'd0, exp_last_err}, bad);
		check_field("hit_count+miss_count", {25'd0, hit_count} + {25'd0, miss_count},
			{25'd0, run_len}, bad);
		if (run_len == 7'd1)
		begin
			check_field("error", {31'd0, error}, 32'd0, bad); // One slot never aliases
		end
		if (prev_valid && prev_seed == 32'd0 && run_seed == 32'd1 && prev_len == run_len)
		begin
			check_field("err_count", {25'd0, err_count}, {25'd0, prev_err}, bad);
			check_field("hit_count", {25'd0, hit_count}, {25'd0, prev_hit}, bad);
			check_field("miss_count", {25'd0, miss_count}, {25'd0, prev_miss}, bad);
		end
		run_count++;
		fail_count += bad;
		$display("run %0d seed 0x%08h len %0d: err_count %0d hit_count %0d miss_count %0d %s",
			run_count, run_seed, run_len, err_count, hit_count, miss_count,
			(bad == 0) ? "ok" : "wrong");
		prev_valid = 1'b1;
		prev_seed  = run_seed;
		prev_len   = run_len;
		prev_err   = err_count;
		prev_hit   = hit_count;
		prev_miss  = miss_count;
	endtask

	// Inputs sampled on the rising edge, outputs on the falling edge
	initial
	begin
		pending    = 1'b0;
		prev_valid = 1'b0;
		wait_cnt   = 0;
		forever
		begin
			@(posedge clk);
			if (rst)
			begin
				for (int k = 0; k < LINES; k++)
				begin
					line_valid[k] = 1'b0; // Cache empty after reset
				end
				pending = 1'b0;
			end
			else if (start && !pending)
			begin
				run_seed = seed;
				run_len  = burst_len;
				predict_run(seed, burst_len);
				pending  = 1'b1;
				wait_cnt = 0;
			end
			@(negedge clk);
			// busy from the cycle after start up to done
			if (busy !== (pending && done !== 1'b1))
			begin
				$display("MISMATCH busy: expected 0x%0h, got 0x%0h",
					pending && done !== 1'b1, busy);
				fail_count++;
			end
			if (!pending && done !== 1'b0)
			begin
				$display("MISMATCH done: expected 0x0, got 0x%0h", done);
				fail_count++;
			end
			if (pending)
			begin
				if (done)
				begin
					compare_run();
					pending = 1'b0;
				end
				else if (wait_cnt >= RUN_TIMEOUT)
				begin
					$display("timeout: run %0d saw no done within %0d cycles",
						run_count + 1, RUN_TIMEOUT);
					fail_count++;
					pending = 1'b0;
				end
				else
				begin
					wait_cnt++;
				end
			end
		end
	end

endmodule

/* verif/dcache_properties.sv */
module dcache_properties (
	input logic                     clk,
	input logic                     rst,
	input dcache_bus_pkg::cpu_req_t cpu_req,
	input logic                     cpu_req_valid,
	input logic                     cpu_req_ready,
	input logic                     cpu_rsp_valid,
	input dcache_bus_pkg::mem_req_t mem_req,
	input logic                     mem_req_valid,
	input logic                     mem_req_ready,
	input logic                     mem_rsp_valid
);
	logic cpu_acc;
	logic mem_acc;
	logic cpu_open;              // CPU request waiting for its response
	logic mem_open;              // Memory request waiting for its response
	int   cpu_hold_fail = 0;
	int   mem_hold_fail = 0;
	int   cpu_pair_fail = 0;
	int   mem_pair_fail = 0;
	int   rst_fail      = 0;
	int   fail_count;            // Read by the testbench top

	assign cpu_acc    = cpu_req_valid && cpu_req_ready;
	assign mem_acc    = mem_req_valid && mem_req_ready;
	assign fail_count = cpu_hold_fail + mem_hold_fail + cpu_pair_fail + mem_pair_fail + rst_fail;

	////////////////////
	// Outstanding flags
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cpu_open <= 1'b0;
			mem_open <= 1'b0;
		end
		else
		begin
			if (cpu_acc)
			begin
				cpu_open <= 1'b1;
			end
			else if (cpu_rsp_valid)
			begin
				cpu_open <= 1'b0;
			end
			if (mem_acc)
			begin
				mem_open <= 1'b1;
			end
			else if (mem_rsp_valid)
			begin
				mem_open <= 1'b0;
			end
		end
	end

	////////////////////
	// Handshake rules
	////////////////////

	// Valid and payload held under back-pressure
	cpu_hold_a: assert property (@(posedge clk) disable iff (rst)
		cpu_req_valid && !cpu_req_ready |=> cpu_req_valid && $stable(cpu_req))
	else
	begin
		$error("cpu request dropped or changed before acceptance");
		cpu_hold_fail++;
	end

	mem_hold_a: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
	else
	begin
		$error("memory request dropped or changed before acceptance");
		mem_hold_fail++;
	end

	// Exactly one response per accepted request
	cpu_pair_a: assert property (@(posedge clk) disable iff (rst)
		(!cpu_rsp_valid || cpu_open) && (!cpu_acc || !cpu_open || cpu_rsp_valid))
	else
	begin
		$error("cpu response without a request, or second request outstanding");
		cpu_pair_fail++;
	end

	mem_pair_a: assert property (@(posedge clk) disable iff (rst)
		(!mem_rsp_valid || mem_open) && (!mem_acc || !mem_open || mem_rsp_valid))
	else
	begin
		$error("memory response without a request, or second request outstanding");
		mem_pair_fail++;
	end

	// All valids quiet right after reset
	rst_quiet_a: assert property (@(posedge clk)
		rst |=> !cpu_req_valid && !cpu_rsp_valid && !mem_req_valid && !mem_rsp_valid)
	else
	begin
		$error("valid signal high after reset");
		rst_fail++;
	end

endmodule

bind dcache dcache_properties props_i (
	.clk           (clk),
	.rst           (rst),
	.cpu_req       (cpu_req),
	.cpu_req_valid (cpu_req_valid),
	.cpu_req_ready (cpu_req_ready),
	.cpu_rsp_valid (cpu_rsp_valid),
	.mem_req       (mem_req),
	.mem_req_valid (mem_req_valid),
	.mem_req_ready (mem_req_ready),
	.mem_rsp_valid (mem_rsp_valid)
);

/* verif/dcache_tb.sv */
module dcache_tb;

	localparam int CYCLE_DELAY   = 3;
	localparam int INDEX_BITS    = 4;
	localparam int MEM_ADDR_BITS = 8;
	localparam int MEM_LATENCY   = 4;
	localparam int RUN_TIMEOUT   = 5000; // Cycles per run
	localparam int RUN_TOTAL     = 16;   // 1 single-slot, 12 random, 1 ignored start, 2 seed runs

	logic        clk;
	logic        rst;
	logic        start;
	logic [31:0] seed;
	logic [6:0]  burst_len;
	logic        busy;
	logic        done;
	logic        error;
	logic [6:0]  err_count;
	logic [6:0]  hit_count;
	logic [6:0]  miss_count;
	logic [31:0] lcg_state;
	logic        timed_out;

	dcache_top #(
		.CYCLE_DELAY   (CYCLE_DELAY),
		.INDEX_BITS    (INDEX_BITS),
		.MEM_ADDR_BITS (MEM_ADDR_BITS),
		.MEM_LATENCY   (MEM_LATENCY)
	) dut_i (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.seed       (seed),
		.burst_len  (burst_len),
		.busy       (busy),
		.done       (done),
		.error      (error),
		.err_count  (err_count),
		.hit_count  (hit_count),
		.miss_count (miss_count)
	);

	dcache_monitor #(
		.INDEX_BITS    (INDEX_BITS),
		.MEM_ADDR_BITS (MEM_ADDR_BITS),
		.RUN_TIMEOUT   (RUN_TIMEOUT)
	) mon_i (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.seed       (seed),
		.burst_len  (burst_len),
		.busy       (busy),
		.done       (done),
		.error      (error),
		.err_count  (err_count),
		.hit_count  (hit_count),
		.miss_count (miss_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk; // Period 20
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] cur);
		return cur * 32'd1664525 + 32'd1013904223;
	endfunction

	// Seed and a length of 1 to 64
	task automatic draw_run(output logic [31:0] run_seed, output logic [6:0] run_len);
		lcg_state = lcg_next(lcg_state);
		run_seed  = lcg_state;
		lcg_state = lcg_next(lcg_state);
		run_len   = {1'b0, lcg_state[21:16]} + 7'd1; // Upper bits, better spread
	endtask

	// One burst, optionally with start pulsed all through it
	task automatic run_burst(input logic [31:0] run_seed, input logic [6:0] run_len,
		input logic extra_start);
		int wait_cnt;
		@(negedge clk);
		seed      = run_seed;
		burst_len = run_len;
		start     = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (extra_start)
		begin
			seed      = ~run_seed; // Must not be picked up
			burst_len = 7'd5;
		end
		wait_cnt = 0;
		while (done !== 1'b1 && wait_cnt < RUN_TIMEOUT)
		begin
			@(negedge clk);
			wait_cnt++;
			start = extra_start && done !== 1'b1 && (wait_cnt % 2 == 1); // Writes and reads
		end
		start     = 1'b0;
		seed      = run_seed;
		burst_len = run_len;
		if (done !== 1'b1)
		begin
			timed_out = 1'b1;
		end
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial
	begin
		logic [31:0] run_seed;
		logic [6:0]  run_len;
		int          total_fail;
		rst       = 1'b1;
		start     = 1'b0;
		seed      = 32'd0;
		burst_len = 7'd0;
		timed_out = 1'b0;
		lcg_state = 32'hc64afff9;
		repeat (3) @(negedge clk); // Three reset cycles
		rst = 1'b0;
		draw_run(run_seed, run_len);
		run_burst(run_seed, 7'd1, 1'b0); // Single slot
		for (int r = 0; r < 12 && !timed_out; r++)
		begin
			draw_run(run_seed, run_len);
			run_burst(run_seed, run_len, 1'b0);
		end
		if (!timed_out)
		begin
			draw_run(run_seed, run_len);
			run_burst(run_seed, run_len, 1'b1); // Start pulsed while busy
		end
		if (!timed_out)
		begin
			draw_run(run_seed, run_len);
			run_burst(32'd0, run_len, 1'b0); // Zero seed, then seed one
		end
		if (!timed_out)
		begin
			run_burst(32'd1, run_len, 1'b0);
		end
		repeat (4) @(negedge clk); // Let the monitor finish
		total_fail = mon_i.fail_count + dut_i.cache_i.props_i.fail_count;
		if (timed_out)
		begin
			$display("timeout: done did not arrive within %0d cycles", RUN_TIMEOUT);
		end
		if (mon_i.run_count != RUN_TOTAL)
		begin
			$display("only %0d of %0d runs were checked", mon_i.run_count, RUN_TOTAL);
		end
		$display("summary: %0d runs, %0d checks, %0d check failures, %0d assertion failures",
			mon_i.run_count, mon_i.check_count, mon_i.fail_count,
			dut_i.cache_i.props_i.fail_count);
		if (total_fail == 0 && !timed_out && mon_i.run_count == RUN_TOTAL)
		begin
			$display("*** PASSED ***");
		end
		else
		begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
